// ==== Bender.yml ====
package:
  name: lbgw

sources:
  # Package and interface first, then the modules bottom up
  - logic/lbgw_pkg.sv
  - logic/wb_if.sv
  - logic/byte_fifo.sv
  - logic/packet_gateway.sv
  - logic/reg_bank.sv
  - logic/lbgw_top.sv

  - target: test
    files:
      - verification/lbgw_tb.sv

// ==== logic/byte_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module byte_fifo import lbgw_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic [7:0] din,
	input logic we,
	input logic re,
	output logic [7:0] dout,
	output logic empty,
	output logic last
);

	localparam int DEPTH = 2 ** FIFO_AW;

	// Storage has no reset, only pointers and count do
	logic [7:0] mem [DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0] count;
	logic full;
	logic do_wr;
	logic do_rd;

	assign full = (count == (FIFO_AW+1)'(DEPTH));
	assign empty = (count == '0);
	// Exactly one byte left
	assign last = (count == (FIFO_AW+1)'(1));

	// Writes into a full buffer are dropped
	assign do_wr = we & ~full;
	assign do_rd = re & ~empty;

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous read and write keeps the count
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	// Oldest byte is always visible
	assign dout = mem[rd_ptr];

endmodule

`default_nettype wire

// ==== logic/lbgw_pkg.sv ====
`default_nettype none

package lbgw_pkg;

	// Local bus widths
	localparam int ADDR_W = 24;
	localparam int DATA_W = 32;

	// Reply FIFO holds 2**FIFO_AW bytes
	localparam int FIFO_AW = 5;

	// Nonce and each transaction are the same length
	localparam int NONCE_BYTES = 8;
	localparam int CNT_W = $clog2(NONCE_BYTES);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(NONCE_BYTES - 1);

	// Read flag position inside the control byte
	localparam int READ_BIT = 4;

	// Register map
	// Indices below REG_ID are plain read/write registers
	localparam int REG_ID = 14;
	localparam int REG_WCOUNT = 15;
	localparam logic [31:0] ID_VALUE = 32'h4c42_4757;

	// Transaction opcode
	typedef enum logic {
		op_write,
		op_read
	} lb_op_t;

	// Receive phase of the gateway
	typedef enum logic [1:0] {
		st_idle,
		st_nonce,
		st_xact
	} gw_state_t;

endpackage

`default_nettype wire

// ==== logic/lbgw_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module lbgw_top (
	input logic clk,
	input logic arst_n,
	// Host receive stream
	input logic [7:0] rx_din,
	input logic rx_stb,
	input logic rx_end,
	// Host reply stream
	output logic [7:0] tx_dout,
	output logic tx_rdy,
	output logic tx_end,
	input logic tx_stb,
	// Register 0 contents
	output logic [31:0] ctrl_out
);

	// Internal Wishbone link, gateway is the only master
	wb_if wb ();

	packet_gateway u_gateway (
		.clk     (clk),
		.arst_n  (arst_n),
		.rx_din  (rx_din),
		.rx_stb  (rx_stb),
		.rx_end  (rx_end),
		.tx_dout (tx_dout),
		.tx_rdy  (tx_rdy),
		.tx_end  (tx_end),
		.tx_stb  (tx_stb),
		.bus     (wb.master)
	);

	reg_bank u_regs (
		.clk      (clk),
		.arst_n   (arst_n),
		.bus      (wb.slave),
		.ctrl_out (ctrl_out)
	);

endmodule

`default_nettype wire

// ==== logic/packet_gateway.sv ====
`timescale 1ns/100ps
`default_nettype none

module packet_gateway import lbgw_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic [7:0] rx_din,
	input logic rx_stb,
	input logic rx_end,
	output logic [7:0] tx_dout,
	output logic tx_rdy,
	output logic tx_end,
	input logic tx_stb,
	wb_if.master bus
);

	localparam int WORD_W = NONCE_BYTES * 8;
	// Field positions inside one big-endian 64-bit transaction
	localparam int ADR_LSB = DATA_W;
	localparam int CTL_LSB = DATA_W + ADDR_W;

	// Receive side
	gw_state_t state;
	logic [CNT_W-1:0] rx_cnt;
	// Seven most recent bytes of the current word
	logic [WORD_W-9:0] rx_sr;
	logic [WORD_W-1:0] rx_next;
	logic word_done;
	logic nonce_done;
	logic xact_done;

	// Bus side
	logic [WORD_W-1:0] xact_q;
	lb_op_t op;
	logic cyc_q;
	logic reply_ld;

	// Serializer and FIFO
	logic [WORD_W-1:0] tx_sr;
	logic [CNT_W-1:0] ser_cnt;
	logic ser_busy;
	logic fifo_empty;
	logic fifo_last;

	// Shift register value including the byte arriving now
	assign rx_next = {rx_sr, rx_din};

	assign word_done = rx_stb && (rx_cnt == CNT_LAST);
	// First word of a packet is the nonce
	assign nonce_done = word_done && (state != st_xact);
	assign xact_done = word_done && (state == st_xact);

	// Receive phase and byte position within the current word
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_idle;
			rx_cnt <= '0;
		end else if (rx_end) begin
			// End of packet wins over a byte in the same cycle
			state <= st_idle;
			rx_cnt <= '0;
		end else if (rx_stb) begin
			rx_cnt <= rx_cnt + 1'b1;
			case (state)
				st_idle: state <= st_nonce;
				st_nonce: if (word_done) state <= st_xact;
				default: state <= st_xact;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rx_stb)
			rx_sr <= rx_next[WORD_W-9:0];
	end

	// Hold the transaction while the next one is shifting in
	always_ff @(posedge clk) begin
		if (xact_done)
			xact_q <= rx_next;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			op <= op_write;
		end else if (xact_done) begin
			op <= rx_next[CTL_LSB+READ_BIT] ? op_read : op_write;
		end
	end

	// Open one classic cycle per transaction
	// The cycle closes in the cycle after ack is sampled
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			cyc_q <= 1'b0;
		else if (xact_done)
			cyc_q <= 1'b1;
		else if (bus.ack)
			cyc_q <= 1'b0;
	end

	assign bus.cyc = cyc_q;
	assign bus.stb = cyc_q;
	assign bus.we = (op == op_write);
	assign bus.adr = xact_q[ADR_LSB+ADDR_W-1:ADR_LSB];
	assign bus.dat_w = xact_q[DATA_W-1:0];

	assign reply_ld = cyc_q & bus.ack;

	// Eight shift steps after each load
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ser_busy <= 1'b0;
			ser_cnt <= '0;
		end else if (nonce_done || reply_ld) begin
			ser_busy <= 1'b1;
			ser_cnt <= '0;
		end else if (ser_busy) begin
			ser_cnt <= ser_cnt + 1'b1;
			if (ser_cnt == CNT_LAST)
				ser_busy <= 1'b0;
		end
	end

	// Nonce is echoed as is
	// Reply keeps control and address
	// Data comes from the bus only on reads
	always_ff @(posedge clk) begin
		if (nonce_done)
			tx_sr <= rx_next;
		else if (reply_ld)
			tx_sr <= {xact_q[WORD_W-1:DATA_W],
				(op == op_read) ? bus.dat_r : xact_q[DATA_W-1:0]};
		else if (ser_busy)
			tx_sr <= {tx_sr[WORD_W-9:0], 8'h00};
	end

	byte_fifo u_fifo (
		.clk    (clk),
		.arst_n (arst_n),
		.din    (tx_sr[WORD_W-1:WORD_W-8]),
		.we     (ser_busy),
		.re     (tx_stb & ~fifo_empty),
		.dout   (tx_dout),
		.empty  (fifo_empty),
		.last   (fifo_last)
	);

	assign tx_rdy = ~fifo_empty;
	// An open bus cycle means a reply word is still on its way
	assign tx_end = fifo_last & (state == st_idle) & ~ser_busy & ~cyc_q;

endmodule

`default_nettype wire

// ==== logic/reg_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_bank import lbgw_pkg::*; (
	input logic clk,
	input logic arst_n,
	wb_if.slave bus,
	output logic [31:0] ctrl_out
);

	// Read/write registers 0 to REG_ID-1
	logic [DATA_W-1:0] regs [REG_ID];
	logic [DATA_W-1:0] wcount;
	logic [DATA_W-1:0] rd_val;
	logic [DATA_W-1:0] dat_q;
	logic [3:0] idx;
	logic in_range;
	logic access;
	logic wr_rw;
	logic ack_q;

	// Only the low sixteen addresses exist
	assign in_range = (bus.adr[ADDR_W-1:4] == '0);
	assign idx = bus.adr[3:0];

	// Accept once per cycle, in the cycle before ack
	assign access = bus.cyc & bus.stb & ~ack_q;
	assign wr_rw = access & bus.we & in_range & (idx < 4'(REG_ID));

	always_comb begin
		if (!in_range)
			rd_val = '0;
		else if (idx == 4'(REG_ID))
			rd_val = ID_VALUE;
		else if (idx == 4'(REG_WCOUNT))
			rd_val = wcount;
		else
			rd_val = regs[idx];
	end

	// Registers read as zero after reset
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < REG_ID; i++)
				regs[i] <= '0;
			wcount <= '0;
		end else if (wr_rw) begin
			regs[idx] <= bus.dat_w;
			// Writes to id, counter or unmapped space are not counted
			wcount <= wcount + 1'b1;
		end
	end

	// Fixed single wait state
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			ack_q <= 1'b0;
		else
			ack_q <= access;
	end

	// Read data lines up with ack
	always_ff @(posedge clk) begin
		if (access)
			dat_q <= rd_val;
	end

	assign bus.ack = ack_q;
	assign bus.dat_r = dat_q;

	assign ctrl_out = regs[0];

endmodule

`default_nettype wire

// ==== logic/wb_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface wb_if import lbgw_pkg::*; ();

	// Cycle and strobe, classic single transfers only
	logic cyc;
	logic stb;
	logic we;
	logic [ADDR_W-1:0] adr;
	logic [DATA_W-1:0] dat_w;

	// Slave answer
	logic [DATA_W-1:0] dat_r;
	logic ack;

	// Gateway side
	modport master (
		output cyc, stb, we, adr, dat_w,
		input dat_r, ack
	);

	// Register bank side
	modport slave (
		input cyc, stb, we, adr, dat_w,
		output dat_r, ack
	);

endinterface

`default_nettype wire

// ==== sim.f ====
logic/lbgw_pkg.sv
logic/wb_if.sv
logic/byte_fifo.sv
logic/packet_gateway.sv
logic/reg_bank.sv
logic/lbgw_top.sv
verification/lbgw_tb.sv

// ==== verification/lbgw_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module lbgw_tb import lbgw_pkg::*; ();

	localparam logic [31:0] SEED = 32'ha46c_a7e9;
	localparam int RESET_CYCLES = 4;
	localparam int NUM_PACKETS = 12;
	localparam int CYCLES_PER_PACKET = 200;
	// Cycles without a reply byte before the reply counts as missing
	localparam int IDLE_LIMIT = 100;

	logic clk;
	logic arst_n;
	logic [7:0] rx_din;
	logic rx_stb;
	logic rx_end;
	logic [7:0] tx_dout;
	logic tx_rdy;
	logic tx_end;
	logic tx_stb;
	logic [31:0] ctrl_out;

	// Register map model
	logic [DATA_W-1:0] model_rw [REG_ID];
	logic [DATA_W-1:0] model_wcount;

	// Current packet, expected words and collected reply
	logic [63:0] xacts [$];
	logic [63:0] exp_words [$];
	logic [7:0] got [$];
	bit got_end [$];
	bit rx_done;

	logic [31:0] rng_rx;
	logic [31:0] rng_tx;
	int mismatches;
	int failures;

	lbgw_top u_dut (
		.clk      (clk),
		.arst_n   (arst_n),
		.rx_din   (rx_din),
		.rx_stb   (rx_stb),
		.rx_end   (rx_end),
		.tx_dout  (tx_dout),
		.tx_rdy   (tx_rdy),
		.tx_end   (tx_end),
		.tx_stb   (tx_stb),
		.ctrl_out (ctrl_out)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// Inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp,
		input logic [7:0] act);
		if (act !== exp) begin
			mismatches++;
			$display("MISMATCH %s: expected 0x%02h, got 0x%02h", name, exp, act);
		end
	endtask

	task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] act);
		if (act !== exp) begin
			mismatches++;
			$display("MISMATCH %s: expected 0x%08h, got 0x%08h", name, exp, act);
		end
	endtask

	task automatic check_ctrl(input logic [31:0] exp);
		if (ctrl_out !== exp) begin
			mismatches++;
			$display("MISMATCH ctrl_out: expected 0x%08h, got 0x%08h", exp, ctrl_out);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			mismatches++;
			$display("MISMATCH %s: expected 0x%0h, got 0x%0h", name, exp, act);
		end
	endtask

	task automatic report_failure(input string what);
		failures++;
		$display("ERROR at %0t: %s", $time, what);
	endtask

	// Out-of-range reads give zero, id and counter are fixed slots
	function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] adr);
		if (adr[ADDR_W-1:4] != '0)
			return '0;
		if (adr[3:0] == 4'(REG_ID))
			return ID_VALUE;
		if (adr[3:0] == 4'(REG_WCOUNT))
			return model_wcount;
		return model_rw[adr[3:0]];
	endfunction

	// Only registers 0 to 13 take writes and count them
	task automatic model_write(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] data);
		if (adr[ADDR_W-1:4] == '0 && adr[3:0] < 4'(REG_ID)) begin
			model_rw[adr[3:0]] = data;
			model_wcount = model_wcount + 1'b1;
		end
	endtask

	// Other control bits carry a tag so the echo is visible
	task automatic add_xact(input bit rd, input logic [ADDR_W-1:0] adr,
		input logic [DATA_W-1:0] data);
		logic [7:0] ctl;
		ctl = 8'h41;
		ctl[READ_BIT] = rd;
		xacts.push_back({ctl, adr, data});
	endtask

	// Big endian, one byte per rx_stb, random idle cycles between
	task automatic send_word(input logic [63:0] w);
		for (int b = 0; b < 8; b++) begin
			rng_rx = xorshift(rng_rx);
			repeat (int'(rng_rx[0])) next_cycle();
			rx_din = w[63-8*b -: 8];
			rx_stb = 1'b1;
			next_cycle();
			rx_stb = 1'b0;
		end
	endtask

	task automatic send_packet(input logic [63:0] nonce);
		send_word(nonce);
		foreach (xacts[i])
			send_word(xacts[i]);
		// End pulse right after the last byte
		rx_end = 1'b1;
		next_cycle();
		rx_end = 1'b0;
		rx_done = 1'b1;
	endtask

	// With hold set, tx_stb stays low until the packet is sent, then pulses randomly
	task automatic collect_reply(input int len, input bit hold);
		int idle;
		idle = 0;
		got.delete();
		got_end.delete();
		while (got.size() < len && idle < IDLE_LIMIT) begin
			rng_tx = xorshift(rng_tx);
			if (!hold)
				tx_stb = 1'b1;
			else
				tx_stb = rx_done & rng_tx[0];
			// Outputs are stable by the falling edge
			@(negedge clk);
			if (tx_stb && tx_rdy) begin
				got.push_back(tx_dout);
				got_end.push_back(tx_end);
				idle = 0;
			end else if (!hold || rx_done) begin
				idle++;
			end
			next_cycle();
		end
		tx_stb = 1'b0;
	endtask

	task automatic run_packet(input logic [63:0] nonce, input bit hold);
		logic [63:0] x;
		logic [63:0] act;
		logic [DATA_W-1:0] data;
		int n;
		int len;
		exp_words.delete();
		exp_words.push_back(nonce);
		// Expected reply words from the model, in packet order
		foreach (xacts[i]) begin
			x = xacts[i];
			data = x[DATA_W-1:0];
			if (x[DATA_W+ADDR_W+READ_BIT])
				data = model_read(x[DATA_W+ADDR_W-1:DATA_W]);
			else
				model_write(x[DATA_W+ADDR_W-1:DATA_W], data);
			exp_words.push_back({x[63:DATA_W], data});
		end
		len = 8 * exp_words.size();
		rx_done = 1'b0;
		fork
			send_packet(nonce);
			collect_reply(len, hold);
		join
		repeat (12) next_cycle();
		if (tx_rdy !== 1'b0)
			report_failure("reply stream holds more bytes than the packet");
		n = got.size();
		if (n != len) begin
			report_failure($sformatf("reply has %0d bytes, expected %0d", n, len));
		end else begin
			for (int w = 0; w < exp_words.size(); w++) begin
				for (int b = 0; b < 8; b++)
					act = {act[55:0], got[8*w+b]};
				// Nonce bytes, then control and address bytes of a transaction
				for (int b = 0; b < ((w == 0) ? 8 : 4); b++)
					check_byte($sformatf("tx_dout word %0d byte %0d", w, b),
						exp_words[w][63-8*b -: 8], act[63-8*b -: 8]);
				if (w > 0)
					check_word($sformatf("tx_dout data of transaction %0d", w),
						exp_words[w][DATA_W-1:0], act[DATA_W-1:0]);
			end
			for (int i = 0; i < n - 1; i++) begin
				if (got_end[i])
					report_failure($sformatf("tx_end high on reply byte %0d of %0d", i, n));
			end
			if (!got_end[n-1])
				report_failure("tx_end missing on the last reply byte");
		end
		xacts.delete();
	endtask

	task automatic test_reset_state();
		check_flag("tx_rdy", 1'b0, tx_rdy);
		check_flag("tx_end", 1'b0, tx_end);
		check_ctrl(32'h0);
		// Data fields of reads are overwritten, so any tag works
		for (int r = 0; r < REG_ID; r++) begin
			add_xact(1'b1, ADDR_W'(r), 32'hdead_0000 | r);
			if (xacts.size() == 3)
				run_packet({32'h5e5e_0000, 32'(r)}, 1'b0);
		end
		if (xacts.size() > 0)
			run_packet(64'h5e5e_ffff_0000_0001, 1'b0);
	endtask

	task automatic test_nonce_echo();
		run_packet(64'h0123_4567_89ab_cdef, 1'b0);
	endtask

	task automatic test_write_read();
		add_xact(1'b0, 24'h000000, 32'hc0de_0001);
		add_xact(1'b0, 24'h000005, 32'h5555_aaaa);
		add_xact(1'b0, 24'h00000d, 32'h1357_9bdf);
		run_packet(64'h1111_2222_3333_4444, 1'b0);
		add_xact(1'b1, 24'h00000d, 32'h0);
		add_xact(1'b1, 24'h000000, 32'h0);
		add_xact(1'b1, 24'h000005, 32'h0);
		run_packet(64'h5555_6666_7777_8888, 1'b0);
		check_ctrl(model_rw[0]);
	endtask

	task automatic test_id_and_count();
		add_xact(1'b1, 24'(REG_ID), 32'h0);
		add_xact(1'b1, 24'(REG_WCOUNT), 32'hffff_ffff);
		run_packet(64'h1d1d_1d1d_c0c0_c0c0, 1'b0);
	endtask

	task automatic test_ignored();
		add_xact(1'b0, 24'(REG_ID), 32'hbad0_0014);
		add_xact(1'b0, 24'(REG_WCOUNT), 32'hbad0_0015);
		// Low nibble aliases register 0 if the upper bits were ignored
		add_xact(1'b0, 24'h000010, 32'hbad0_0010);
		run_packet(64'h9999_aaaa_bbbb_cccc, 1'b0);
		check_ctrl(model_rw[0]);
		add_xact(1'b1, 24'(REG_WCOUNT), 32'h0);
		add_xact(1'b1, 24'h800005, 32'h1234_5678);
		add_xact(1'b1, 24'h000000, 32'h0);
		run_packet(64'hdddd_eeee_ffff_0000, 1'b0);
	endtask

	// Full 32 byte reply parked in the FIFO before it drains
	task automatic test_backpressure();
		add_xact(1'b0, 24'h000007, 32'hfeed_beef);
		add_xact(1'b1, 24'h000007, 32'h0);
		add_xact(1'b1, 24'h00000d, 32'h0);
		run_packet(64'hb0b0_b1b1_b2b2_b3b3, 1'b1);
		check_ctrl(model_rw[0]);
	endtask

	initial begin
		arst_n = 1'b0;
		rx_din = 8'h00;
		rx_stb = 1'b0;
		rx_end = 1'b0;
		tx_stb = 1'b0;
		rx_done = 1'b0;
		rng_rx = SEED;
		rng_tx = xorshift(SEED);
		mismatches = 0;
		failures = 0;
		model_wcount = '0;
		for (int i = 0; i < REG_ID; i++)
			model_rw[i] = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		arst_n = 1'b1;
		test_reset_state();
		test_nonce_echo();
		test_write_read();
		test_id_and_count();
		test_ignored();
		test_backpressure();
		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog sized from the packet count
	initial begin
		repeat (RESET_CYCLES + NUM_PACKETS * CYCLES_PER_PACKET) @(posedge clk);
		failures++;
		$display("ERROR at %0t: watchdog expired before the tests finished", $time);
		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
